// File: sources.f
fpu_pkg.sv
operand_forward.sv
fpu_decode.sv
fp_permute.sv
fp_compare.sv
fp_except.sv
fpu_unit.sv
tb_fpu_unit.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, then run it
verilator --binary --timing --assert -f sources.f --top-module tb_fpu_unit -o sim_fpu \
  && ./obj_dir/sim_fpu \
  || { echo "simulation failed"; exit 1; }

// File: tb_fpu_unit.sv
module tb_fpu_unit;

  localparam int NUM_FWD     = 4;
  localparam int DW          = fpu_pkg::DATA_W;
  localparam int DRAIN_LIMIT = 20;

  // forward bus tags for the cycle before issue and the issue cycle
  localparam logic [31:0] TAG_PREV = 32'h2222_bbbb;
  localparam logic [31:0] TAG_NOW  = 32'h1111_aaaa;

  localparam fpu_pkg::data_t PAT     = 64'h0123_4567_89ab_cdef;
  localparam fpu_pkg::data_t JUNK    = 64'hdead_beef_dead_beef;
  localparam fpu_pkg::data_t MASK_A  = 64'hf0f0_f0f0_ff00_ff00;
  localparam fpu_pkg::data_t MASK_B  = 64'hcccc_cccc_0f0f_0f0f;
  localparam fpu_pkg::data_t HI_ONES = 64'hffff_ffff_0000_0000;
  // doubles for the compare lane
  localparam fpu_pkg::data_t ONE    = 64'h3ff0_0000_0000_0000;
  localparam fpu_pkg::data_t TWO    = 64'h4000_0000_0000_0000;
  localparam fpu_pkg::data_t M_ONE  = 64'hbff0_0000_0000_0000;
  localparam fpu_pkg::data_t M_TWO  = 64'hc000_0000_0000_0000;
  localparam fpu_pkg::data_t N_ZERO = 64'h8000_0000_0000_0000;
  localparam fpu_pkg::data_t QNAN   = 64'h7ff8_0000_0000_0000;
  localparam fpu_pkg::data_t SNAN   = 64'h7ff0_0000_0000_0001;
  localparam fpu_pkg::data_t DEN    = 64'h0000_0000_0000_0001;

  localparam fpu_pkg::ret_code_e RET_OK  = fpu_pkg::ret_ok;
  localparam fpu_pkg::ret_code_e RET_INV = fpu_pkg::ret_invalid;
  localparam fpu_pkg::ret_code_e RET_DEN = fpu_pkg::ret_denormal;

  logic                         clk = 1'b0;
  logic                         rst;
  logic                         in_valid;
  fpu_pkg::fpu_op_e             op;
  fpu_pkg::data_t               a_reg;
  fpu_pkg::data_t               b_reg;
  logic [NUM_FWD-1:0]           a_fwd_now;
  logic [NUM_FWD-1:0]           b_fwd_now;
  logic [NUM_FWD-1:0]           a_fwd_prev;
  logic [NUM_FWD-1:0]           b_fwd_prev;
  fpu_pkg::data_t [NUM_FWD-1:0] fwd_bus;
  logic [1:0]                   trap_en;
  logic                         out_valid;
  fpu_pkg::data_t               result;
  fpu_pkg::flags_t              flags;
  fpu_pkg::ret_code_e           ret_code;

  // stimulus table columns indexed by entry
  fpu_pkg::fpu_op_e     t_op[$];
  fpu_pkg::data_t       t_a[$];
  fpu_pkg::data_t       t_b[$];
  logic [4*NUM_FWD-1:0] t_sel[$];
  logic [1:0]           t_trap[$];
  fpu_pkg::data_t       t_res[$];
  fpu_pkg::flags_t      t_flags[$];
  fpu_pkg::ret_code_e   t_ret[$];
  // operations in flight
  int                   exp_cyc[$];
  fpu_pkg::data_t       exp_res[$];
  fpu_pkg::flags_t      exp_flags[$];
  fpu_pkg::ret_code_e   exp_ret[$];

  int               cyc = 0;
  int               waited;
  logic [63:0]      rng;
  fpu_pkg::data_t   rand_a;
  fpu_pkg::data_t   rand_b;
  fpu_pkg::fpu_op_e rand_op;

  fpu_unit #(.NUM_FWD(NUM_FWD)) dut_i (.*);

  always #4 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  function automatic logic [63:0] xorshift(input logic [63:0] s);
    logic [63:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  // bus i carries the tag in its high half and i in its low half
  function automatic logic [NUM_FWD*DW-1:0] make_bus(input logic [31:0] tag);
    logic [NUM_FWD*DW-1:0] bus;
    for (int i = 0; i < NUM_FWD; i++) begin
      bus[i*DW +: DW] = {tag, 32'(i)};
    end
    return bus;
  endfunction

  function automatic fpu_pkg::data_t logic_ref(input fpu_pkg::fpu_op_e o,
                                               input fpu_pkg::data_t a, input fpu_pkg::data_t b);
    case (o)
      fpu_pkg::op_and: return a & b;
      fpu_pkg::op_or:  return a | b;
      default:         return a ^ b;
    endcase
  endfunction

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "simulation stopped at time %0t", $time);
  endtask

  task automatic add_entry(input fpu_pkg::fpu_op_e o, input fpu_pkg::data_t a,
                           input fpu_pkg::data_t b, input logic [4*NUM_FWD-1:0] sel,
                           input logic [1:0] trap, input fpu_pkg::data_t res,
                           input fpu_pkg::flags_t fl, input fpu_pkg::ret_code_e rc);
    t_op.push_back(o);
    t_a.push_back(a);
    t_b.push_back(b);
    t_sel.push_back(sel);
    t_trap.push_back(trap);
    t_res.push_back(res);
    t_flags.push_back(fl);
    t_ret.push_back(rc);
  endtask

  // selects are {a_now, b_now, a_prev, b_prev}
  task automatic load_table();
    add_entry(fpu_pkg::op_mov,  PAT, JUNK, 16'h0, 2'b00, PAT, 4'h0, RET_OK);
    add_entry(fpu_pkg::op_swap, PAT, JUNK, 16'h0, 2'b11, 64'h89ab_cdef_0123_4567, 4'h0, RET_OK);
    add_entry(fpu_pkg::op_dup,  PAT, JUNK, 16'h0, 2'b00, 64'h89ab_cdef_89ab_cdef, 4'h0, RET_OK);
    add_entry(fpu_pkg::op_and, MASK_A, MASK_B, 16'h0, 2'b00, 64'hc0c0_c0c0_0f00_0f00, 4'h0, RET_OK);
    add_entry(fpu_pkg::op_or,  MASK_A, MASK_B, 16'h0, 2'b00, 64'hfcfc_fcfc_ff0f_ff0f, 4'h0, RET_OK);
    add_entry(fpu_pkg::op_xor, MASK_A, MASK_B, 16'h0, 2'b00, 64'h3c3c_3c3c_f00f_f00f, 4'h0, RET_OK);
    // no trap from the permute lane, even for an snan
    add_entry(fpu_pkg::op_mov,  SNAN, DEN, 16'h0, 2'b11, SNAN, 4'h0, RET_OK);
    add_entry(fpu_pkg::op_mov, JUNK, JUNK, 16'h4000, 2'b00, 64'h1111_aaaa_0000_0002, 4'h0, RET_OK);
    add_entry(fpu_pkg::op_mov, JUNK, JUNK, 16'h0020, 2'b00, 64'h2222_bbbb_0000_0001, 4'h0, RET_OK);
    add_entry(fpu_pkg::op_mov, JUNK, JUNK, 16'h8010, 2'b00, 64'h1111_aaaa_0000_0003, 4'h0, RET_OK);
    add_entry(fpu_pkg::op_xor, HI_ONES, JUNK, 16'h0008, 2'b00, 64'hdddd_4444_0000_0003, 4'h0, RET_OK);
    add_entry(fpu_pkg::op_and, HI_ONES, JUNK, 16'h0104, 2'b00, 64'h1111_aaaa_0000_0000, 4'h0, RET_OK);
    // compares give the flags word as result
    add_entry(fpu_pkg::op_cmp_q, ONE, TWO, 16'h0, 2'b11, 64'h2, 4'h2, RET_OK);
    add_entry(fpu_pkg::op_cmp_q, TWO, M_ONE, 16'h0, 2'b11, 64'h4, 4'h4, RET_OK);
    add_entry(fpu_pkg::op_cmp_q, M_TWO, M_ONE, 16'h0, 2'b11, 64'h2, 4'h2, RET_OK);
    add_entry(fpu_pkg::op_cmp_q, ONE, ONE, 16'h0, 2'b11, 64'h1, 4'h1, RET_OK);
    add_entry(fpu_pkg::op_cmp_q, 64'h0, N_ZERO, 16'h0, 2'b11, 64'h1, 4'h1, RET_OK);
    add_entry(fpu_pkg::op_cmp_q, QNAN, ONE, 16'h0, 2'b11, 64'h8, 4'h8, RET_OK);
    add_entry(fpu_pkg::op_cmp_s, QNAN, ONE, 16'h0, 2'b01, 64'h8, 4'h8, RET_INV);
    add_entry(fpu_pkg::op_cmp_s, QNAN, ONE, 16'h0, 2'b10, 64'h8, 4'h8, RET_OK);
    add_entry(fpu_pkg::op_cmp_q, ONE, SNAN, 16'h0, 2'b01, 64'h8, 4'h8, RET_INV);
    add_entry(fpu_pkg::op_cmp_q, DEN, ONE, 16'h0, 2'b10, 64'h2, 4'h2, RET_DEN);
    add_entry(fpu_pkg::op_cmp_q, DEN, ONE, 16'h0, 2'b01, 64'h2, 4'h2, RET_OK);
    add_entry(fpu_pkg::op_cmp_s, DEN, QNAN, 16'h0, 2'b11, 64'h8, 4'h8, RET_INV);
  endtask

  task automatic launch(input fpu_pkg::fpu_op_e o, input fpu_pkg::data_t a,
                        input fpu_pkg::data_t b, input logic [4*NUM_FWD-1:0] sel,
                        input logic [1:0] trap, input fpu_pkg::data_t res,
                        input fpu_pkg::flags_t fl, input fpu_pkg::ret_code_e rc);
    in_valid = 1'b1;
    op       = o;
    a_reg    = a;
    b_reg    = b;
    trap_en  = trap;
    fwd_bus  = make_bus(TAG_NOW);
    {a_fwd_now, b_fwd_now, a_fwd_prev, b_fwd_prev} = sel;
    // sampled at the next rising edge and due two edges later
    exp_cyc.push_back(cyc + 2);
    exp_res.push_back(res);
    exp_flags.push_back(fl);
    exp_ret.push_back(rc);
  endtask

  task automatic idle();
    in_valid = 1'b0;
    fwd_bus  = make_bus(TAG_PREV);
    {a_fwd_now, b_fwd_now, a_fwd_prev, b_fwd_prev} = '0;
    // opposite lane and enables while nothing is issued
    if (op == fpu_pkg::op_cmp_q || op == fpu_pkg::op_cmp_s) begin
      op = fpu_pkg::op_xor;
    end else begin
      op = fpu_pkg::op_cmp_s;
    end
    trap_en = ~trap_en;
  endtask

  // outputs are stable at the falling edge
  task automatic tick();
    @(negedge clk);
    if (out_valid) begin
      assert (exp_cyc.size() > 0 && exp_cyc[0] == cyc) else begin
        $display("out_valid was high at cycle %0d with no result due then", cyc);
        abort_run();
      end
      assert (result == exp_res[0] && flags == exp_flags[0] && ret_code == exp_ret[0]) else begin
        $display("ERROR at %0t: got %h %h %0d, expected %h %h %0d", $time, result, flags,
                 ret_code, exp_res[0], exp_flags[0], exp_ret[0]);
        abort_run();
      end
      exp_cyc.delete(0);
      exp_res.delete(0);
      exp_flags.delete(0);
      exp_ret.delete(0);
    end else if (exp_cyc.size() > 0) begin
      assert (exp_cyc[0] > cyc) else begin
        $display("the operation due at cycle %0d never raised out_valid", exp_cyc[0]);
        abort_run();
      end
    end
  endtask

  initial begin
    rng      = 64'd5;
    rst      = 1'b1;
    in_valid = 1'b0;
    op       = fpu_pkg::op_mov;
    a_reg    = '0;
    b_reg    = '0;
    trap_en  = '0;
    fwd_bus  = '0;
    {a_fwd_now, b_fwd_now, a_fwd_prev, b_fwd_prev} = '0;
    load_table();
    repeat (5) tick();
    assert (!out_valid && result == '0 && flags == '0 && ret_code == RET_OK) else begin
      $display("ERROR at %0t: outputs not cleared by reset", $time);
      abort_run();
    end
    rst = 1'b0;
    // quiet cycles with nothing issued
    repeat (3) tick();
    for (int i = 0; i < t_op.size(); i++) begin
      tick();
      idle();
      tick();
      launch(t_op[i], t_a[i], t_b[i], t_sel[i], t_trap[i], t_res[i], t_flags[i], t_ret[i]);
    end
    // back-to-back logic ops on random operands
    for (int i = 0; i < 12; i++) begin
      tick();
      rng    = xorshift(rng);
      rand_a = rng;
      rng    = xorshift(rng);
      rand_b = rng;
      case (i % 3)
        0:       rand_op = fpu_pkg::op_and;
        1:       rand_op = fpu_pkg::op_or;
        default: rand_op = fpu_pkg::op_xor;
      endcase
      launch(rand_op, rand_a, rand_b, '0, 2'b11, logic_ref(rand_op, rand_a, rand_b), 4'h0, RET_OK);
    end
    tick();
    idle();
    waited = 0;
    while (exp_cyc.size() > 0 && waited < DRAIN_LIMIT) begin
      tick();
      waited++;
    end
    if (exp_cyc.size() > 0) begin
      $display("timeout, no result arrived for %0d issued operations", exp_cyc.size());
      abort_run();
    end else begin
      repeat (4) tick();
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// File: fpu_unit.sv
module fpu_unit #(
  parameter int NUM_FWD = 4
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         in_valid,
  input  fpu_pkg::fpu_op_e             op,
  input  fpu_pkg::data_t               a_reg,
  input  fpu_pkg::data_t               b_reg,
  input  logic [NUM_FWD-1:0]           a_fwd_now,
  input  logic [NUM_FWD-1:0]           b_fwd_now,
  input  logic [NUM_FWD-1:0]           a_fwd_prev,
  input  logic [NUM_FWD-1:0]           b_fwd_prev,
  input  fpu_pkg::data_t [NUM_FWD-1:0] fwd_bus,
  input  logic [1:0]                   trap_en,
  output logic                         out_valid,
  output fpu_pkg::data_t               result,
  output fpu_pkg::flags_t              flags,
  output fpu_pkg::ret_code_e           ret_code
);

  fpu_pkg::data_t   a_opnd;
  fpu_pkg::data_t   b_opnd;
  logic             stage_valid;
  logic             is_cmp;
  logic             cmp_signaling;
  fpu_pkg::fpu_op_e perm_op;
  logic [1:0]       stage_trap_en;
  fpu_pkg::data_t   perm_result;
  fpu_pkg::flags_t  cmp_flags;
  logic             raise_invalid;
  logic             raise_denormal;
  logic             cmp_q;

  operand_forward #(
    .NUM_FWD(NUM_FWD)
  ) operand_forward_i (
    .clk        (clk),
    .rst        (rst),
    .a_reg      (a_reg),
    .b_reg      (b_reg),
    .a_fwd_now  (a_fwd_now),
    .b_fwd_now  (b_fwd_now),
    .a_fwd_prev (a_fwd_prev),
    .b_fwd_prev (b_fwd_prev),
    .fwd_bus    (fwd_bus),
    .a_opnd     (a_opnd),
    .b_opnd     (b_opnd)
  );

  fpu_decode fpu_decode_i (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .op            (op),
    .trap_en       (trap_en),
    .stage_valid   (stage_valid),
    .is_cmp        (is_cmp),
    .cmp_signaling (cmp_signaling),
    .perm_op       (perm_op),
    .stage_trap_en (stage_trap_en)
  );

  fp_permute fp_permute_i (
    .clk         (clk),
    .rst         (rst),
    .perm_op     (perm_op),
    .a_opnd      (a_opnd),
    .b_opnd      (b_opnd),
    .perm_result (perm_result)
  );

  fp_compare fp_compare_i (
    .clk            (clk),
    .rst            (rst),
    .cmp_signaling  (cmp_signaling),
    .a_opnd         (a_opnd),
    .b_opnd         (b_opnd),
    .cmp_flags      (cmp_flags),
    .raise_invalid  (raise_invalid),
    .raise_denormal (raise_denormal)
  );

  fp_except fp_except_i (
    .clk            (clk),
    .rst            (rst),
    .is_cmp         (is_cmp),
    .stage_trap_en  (stage_trap_en),
    .raise_invalid  (raise_invalid),
    .raise_denormal (raise_denormal),
    .ret_code       (ret_code)
  );

  // valid and lane select aligned with the lane outputs
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      cmp_q     <= 1'b0;
    end else begin
      out_valid <= stage_valid;
      cmp_q     <= is_cmp;
    end
  end

  // compare result is the flags word zero-extended
  assign result = cmp_q ?
    {{(fpu_pkg::DATA_W - fpu_pkg::FLAG_W){1'b0}}, cmp_flags} : perm_result;
  assign flags  = cmp_q ? cmp_flags : '0;

endmodule

// File: fp_except.sv
module fp_except (
  input  logic               clk,
  input  logic               rst,
  input  logic               is_cmp,
  input  logic [1:0]         stage_trap_en,
  input  logic               raise_invalid,
  input  logic               raise_denormal,
  output fpu_pkg::ret_code_e ret_code
);

  logic       is_cmp_q;
  logic [1:0] trap_en_q;
  logic       trap_inv;
  logic       trap_den;

  // lane select and enables follow the causes by one stage
  always_ff @(posedge clk) begin
    if (rst) begin
      is_cmp_q  <= 1'b0;
      trap_en_q <= '0;
    end else begin
      is_cmp_q  <= is_cmp;
      trap_en_q <= stage_trap_en;
    end
  end

  assign trap_inv = is_cmp_q && raise_invalid && trap_en_q[fpu_pkg::TRAP_INV];
  assign trap_den = is_cmp_q && raise_denormal && trap_en_q[fpu_pkg::TRAP_DEN];

  // invalid outranks denormal
  always_comb begin
    if (trap_inv) begin
      ret_code = fpu_pkg::ret_invalid;
    end else if (trap_den) begin
      ret_code = fpu_pkg::ret_denormal;
    end else begin
      ret_code = fpu_pkg::ret_ok;
    end
  end

endmodule

// File: fp_compare.sv
module fp_compare (
  input  logic            clk,
  input  logic            rst,
  input  logic            cmp_signaling,
  input  fpu_pkg::data_t  a_opnd,
  input  fpu_pkg::data_t  b_opnd,
  output fpu_pkg::flags_t cmp_flags,
  output logic            raise_invalid,
  output logic            raise_denormal
);

  localparam int FW = fpu_pkg::FRAC_W;
  localparam int EW = fpu_pkg::EXP_W;

  logic          a_sign;
  logic          b_sign;
  logic [EW-1:0] a_exp;
  logic [EW-1:0] b_exp;
  logic [FW-1:0] a_frac;
  logic [FW-1:0] b_frac;

  logic a_nan, b_nan;
  logic a_snan, b_snan;
  logic a_zero, b_zero;
  logic a_den, b_den;
  logic mag_lt, mag_eq;
  logic less;

  fpu_pkg::flags_t flags_next;

  assign a_sign = a_opnd[fpu_pkg::DATA_W-1];
  assign b_sign = b_opnd[fpu_pkg::DATA_W-1];
  assign a_exp  = a_opnd[FW+EW-1:FW];
  assign b_exp  = b_opnd[FW+EW-1:FW];
  assign a_frac = a_opnd[FW-1:0];
  assign b_frac = b_opnd[FW-1:0];

  // operand classes
  assign a_nan  = (&a_exp) && (|a_frac);
  assign b_nan  = (&b_exp) && (|b_frac);
  // quiet bit is the top fraction bit
  assign a_snan = a_nan && !a_frac[FW-1];
  assign b_snan = b_nan && !b_frac[FW-1];
  assign a_zero = (a_exp == '0) && (a_frac == '0);
  assign b_zero = (b_exp == '0) && (b_frac == '0);
  assign a_den  = (a_exp == '0) && (|a_frac);
  assign b_den  = (b_exp == '0) && (|b_frac);

  // magnitude order, exponent above fraction
  assign mag_lt = {a_exp, a_frac} < {b_exp, b_frac};
  assign mag_eq = {a_exp, a_frac} == {b_exp, b_frac};
  // negative magnitudes order the other way round
  assign less   = (a_sign != b_sign) ? a_sign : (a_sign ^ mag_lt);

  always_comb begin
    flags_next = '0;
    if (a_nan || b_nan) begin
      flags_next[fpu_pkg::FLAG_UN] = 1'b1;
    end else if ((a_zero && b_zero) || ((a_sign == b_sign) && mag_eq)) begin
      flags_next[fpu_pkg::FLAG_EQ] = 1'b1;
    end else if (less) begin
      flags_next[fpu_pkg::FLAG_LT] = 1'b1;
    end else begin
      flags_next[fpu_pkg::FLAG_GT] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cmp_flags      <= '0;
      raise_invalid  <= 1'b0;
      raise_denormal <= 1'b0;
    end else begin
      cmp_flags      <= flags_next;
      // signaling compare traps on any nan, quiet one only on snan
      raise_invalid  <= cmp_signaling ? (a_nan || b_nan) : (a_snan || b_snan);
      raise_denormal <= a_den || b_den;
    end
  end

endmodule

// File: fp_permute.sv
module fp_permute (
  input  logic             clk,
  input  logic             rst,
  input  fpu_pkg::fpu_op_e perm_op,
  input  fpu_pkg::data_t   a_opnd,
  input  fpu_pkg::data_t   b_opnd,
  output fpu_pkg::data_t   perm_result
);

  localparam int HW = fpu_pkg::HALF_W;

  fpu_pkg::data_t perm_next;

  always_comb begin
    case (perm_op)
      // exchange the two single halves
      fpu_pkg::op_swap: begin
        perm_next = {a_opnd[HW-1:0], a_opnd[fpu_pkg::DATA_W-1:HW]};
      end
      // low single copied into both halves
      fpu_pkg::op_dup: begin
        perm_next = {a_opnd[HW-1:0], a_opnd[HW-1:0]};
      end
      fpu_pkg::op_and: begin
        perm_next = a_opnd & b_opnd;
      end
      fpu_pkg::op_or: begin
        perm_next = a_opnd | b_opnd;
      end
      fpu_pkg::op_xor: begin
        perm_next = a_opnd ^ b_opnd;
      end
      default: begin
        perm_next = a_opnd;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      perm_result <= '0;
    end else begin
      perm_result <= perm_next;
    end
  end

endmodule

// File: fpu_decode.sv
module fpu_decode (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  fpu_pkg::fpu_op_e op,
  input  logic [1:0]       trap_en,
  output logic             stage_valid,
  output logic             is_cmp,
  output logic             cmp_signaling,
  output fpu_pkg::fpu_op_e perm_op,
  output logic [1:0]       stage_trap_en
);

  fpu_pkg::fpu_op_e op_q;

  // issue stage registers
  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid   <= 1'b0;
      op_q          <= fpu_pkg::op_mov;
      stage_trap_en <= '0;
    end else begin
      stage_valid   <= in_valid;
      op_q          <= op;
      stage_trap_en <= trap_en;
    end
  end

  // lane controls from the registered opcode
  always_comb begin
    is_cmp        = (op_q == fpu_pkg::op_cmp_q) || (op_q == fpu_pkg::op_cmp_s);
    cmp_signaling = (op_q == fpu_pkg::op_cmp_s);
    perm_op       = op_q;
  end

endmodule

// File: operand_forward.sv
module operand_forward #(
  parameter int NUM_FWD = 4
) (
  input  logic                                clk,
  input  logic                                rst,
  input  fpu_pkg::data_t                      a_reg,
  input  fpu_pkg::data_t                      b_reg,
  input  logic [NUM_FWD-1:0]                  a_fwd_now,
  input  logic [NUM_FWD-1:0]                  b_fwd_now,
  input  logic [NUM_FWD-1:0]                  a_fwd_prev,
  input  logic [NUM_FWD-1:0]                  b_fwd_prev,
  input  fpu_pkg::data_t [NUM_FWD-1:0]        fwd_bus,
  output fpu_pkg::data_t                      a_opnd,
  output fpu_pkg::data_t                      b_opnd
);

  // last cycle's value of every forward bus
  fpu_pkg::data_t [NUM_FWD-1:0] fwd_bus_q;

  // live select wins over previous, register value as fallback
  function automatic fpu_pkg::data_t pick_operand(
    input fpu_pkg::data_t               reg_val,
    input logic [NUM_FWD-1:0]           sel_now,
    input logic [NUM_FWD-1:0]           sel_prev,
    input fpu_pkg::data_t [NUM_FWD-1:0] bus_now,
    input fpu_pkg::data_t [NUM_FWD-1:0] bus_prev
  );
    fpu_pkg::data_t now_val;
    fpu_pkg::data_t prev_val;
    now_val  = '0;
    prev_val = '0;
    // selects are one-hot, so an and-or mux is enough
    for (int i = 0; i < NUM_FWD; i++) begin
      now_val  = now_val | (bus_now[i] & {fpu_pkg::DATA_W{sel_now[i]}});
      prev_val = prev_val | (bus_prev[i] & {fpu_pkg::DATA_W{sel_prev[i]}});
    end
    if (|sel_now) begin
      return now_val;
    end else if (|sel_prev) begin
      return prev_val;
    end
    return reg_val;
  endfunction

  always_ff @(posedge clk) begin
    fwd_bus_q <= fwd_bus;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      a_opnd <= '0;
      b_opnd <= '0;
    end else begin
      a_opnd <= pick_operand(a_reg, a_fwd_now, a_fwd_prev, fwd_bus, fwd_bus_q);
      b_opnd <= pick_operand(b_reg, b_fwd_now, b_fwd_prev, fwd_bus, fwd_bus_q);
    end
  end

endmodule

// File: fpu_pkg.sv
package fpu_pkg;

  // operand and result width
  localparam int DATA_W = 64;
  localparam int HALF_W = DATA_W / 2;

  // double precision fields
  localparam int EXP_W  = 11;
  localparam int FRAC_W = 52;

  typedef logic [DATA_W-1:0] data_t;

  typedef enum logic [3:0] {
    op_mov   = 4'd0,
    op_swap  = 4'd1,
    op_dup   = 4'd2,
    op_and   = 4'd3,
    op_or    = 4'd4,
    op_xor   = 4'd5,
    op_cmp_q = 4'd6,
    op_cmp_s = 4'd7
  } fpu_op_e;

  typedef enum logic [1:0] {
    ret_ok       = 2'd0,
    ret_invalid  = 2'd1,
    ret_denormal = 2'd2
  } ret_code_e;

  // compare flag bit positions
  localparam int FLAG_W  = 4;
  localparam int FLAG_EQ = 0;
  localparam int FLAG_LT = 1;
  localparam int FLAG_GT = 2;
  localparam int FLAG_UN = 3;

  typedef logic [FLAG_W-1:0] flags_t;

  // trap enable bits from the fpu control register
  localparam int TRAP_INV = 0;
  localparam int TRAP_DEN = 1;

endpackage
